// File: hw/ppu_consts.svh
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Visible screen area
`define PPU_SCREEN_WIDTH 160
`define PPU_SCREEN_HEIGHT 144

// Line and frame timing in dots
`define PPU_DOTS_PER_LINE 456
`define PPU_LINES_PER_FRAME 154
`define PPU_OAM_SCAN_DOTS 80

// Pixel FIFO entries, must be a power of two
`define PPU_FIFO_DEPTH 16

`endif

// File: hw/ppu_pkg.sv
package ppu_pkg;

  // Colour index as read from the two bitplanes
  typedef logic [1:0] gb_color_t;

  // Shade after palette lookup
  typedef logic [1:0] gb_shade_t;

  // Screen x or y, also the current line
  typedef logic [7:0] screen_coord_t;

  // y * 160 + x
  typedef logic [14:0] fb_addr_t;

  // Dot position within a line, 0 to 455
  typedef logic [8:0] dot_count_t;

  // Pixel FIFO fill level, 0 to depth
  typedef logic [4:0] fifo_count_t;

  typedef enum logic [1:0] {
    mode_hblank   = 2'd0,
    mode_vblank   = 2'd1,
    mode_oam_scan = 2'd2,
    mode_draw     = 2'd3
  } ppu_mode_t;

  // Bit 7 of each plane is the leftmost pixel
  typedef struct packed {
    logic [7:0] plane_lo;
    logic [7:0] plane_hi;
  } tile_row_t;

endpackage

// File: hw/ppu_mode_ctrl.sv
`include "ppu_consts.svh"

module ppu_mode_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   flush,
  input  logic                   line_done,
  output logic                   dot_en,
  output ppu_pkg::ppu_mode_t     mode,
  output ppu_pkg::screen_coord_t ly
);

  localparam ppu_pkg::dot_count_t last_dot =
    ppu_pkg::dot_count_t'(`PPU_DOTS_PER_LINE - 1);
  localparam ppu_pkg::dot_count_t oam_last_dot =
    ppu_pkg::dot_count_t'(`PPU_OAM_SCAN_DOTS - 1);
  localparam ppu_pkg::screen_coord_t last_line =
    ppu_pkg::screen_coord_t'(`PPU_LINES_PER_FRAME - 1);
  localparam ppu_pkg::screen_coord_t last_visible_line =
    ppu_pkg::screen_coord_t'(`PPU_SCREEN_HEIGHT - 1);

  ppu_pkg::ppu_mode_t     mode_q;
  ppu_pkg::dot_count_t    dot_q;
  ppu_pkg::screen_coord_t ly_q;
  ppu_pkg::screen_coord_t ly_next;
  logic                   line_end;
  logic                   dot_hold;

  always_comb begin
    // A late draw parks the dot counter at the last dot
    dot_hold = (mode_q == ppu_pkg::mode_draw) && (dot_q == last_dot);
    if (mode_q == ppu_pkg::mode_draw) begin
      line_end = dot_hold && line_done;
    end else begin
      line_end = (dot_q == last_dot);
    end
    ly_next = (ly_q == last_line) ? '0 : ly_q + 8'd1;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode_q <= ppu_pkg::mode_oam_scan;
      dot_q  <= '0;
      ly_q   <= '0;
    end else if (flush) begin
      mode_q <= ppu_pkg::mode_oam_scan;
      dot_q  <= '0;
      ly_q   <= '0;
    end else if (line_end) begin
      dot_q <= '0;
      ly_q  <= ly_next;
      if (ly_next <= last_visible_line) begin
        mode_q <= ppu_pkg::mode_oam_scan;
      end else begin
        mode_q <= ppu_pkg::mode_vblank;
      end
    end else begin
      if (!dot_hold) begin
        dot_q <= dot_q + 9'd1;
      end
      case (mode_q)
        ppu_pkg::mode_oam_scan: begin
          if (dot_q == oam_last_dot) begin
            mode_q <= ppu_pkg::mode_draw;
          end
        end
        ppu_pkg::mode_draw: begin
          // Framebuffer finished the line
          if (line_done) begin
            mode_q <= ppu_pkg::mode_hblank;
          end
        end
        default: begin
          mode_q <= mode_q;
        end
      endcase
    end
  end

  assign mode   = mode_q;
  assign ly     = ly_q;
  assign dot_en = (mode_q == ppu_pkg::mode_draw);

  // The framebuffer only finishes lines while we are drawing
  a_line_done_in_draw: assert property (
    @(posedge clk) disable iff (reset || flush)
    line_done |-> mode_q == ppu_pkg::mode_draw
  );

endmodule

// File: hw/tile_row_decoder.sv
`include "ppu_consts.svh"

module tile_row_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 tile_push,
  input  ppu_pkg::tile_row_t   tile_row,
  input  ppu_pkg::fifo_count_t fifo_count,
  output logic                 tile_ready,
  output logic                 write_en,
  output ppu_pkg::gb_color_t   write_data
);

  // Room for a full row of eight pixels
  localparam ppu_pkg::fifo_count_t ready_level =
    ppu_pkg::fifo_count_t'(`PPU_FIFO_DEPTH - 8);

  logic [7:0] lo_sr;
  logic [7:0] hi_sr;
  logic [2:0] pix_q;
  logic       busy_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      pix_q  <= '0;
    end else if (flush) begin
      busy_q <= 1'b0;
      pix_q  <= '0;
    end else if (tile_push) begin
      busy_q <= 1'b1;
      pix_q  <= '0;
    end else if (busy_q) begin
      pix_q <= pix_q + 3'd1;
      if (pix_q == 3'd7) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Shift registers move the next pixel into bit 7
  always_ff @(posedge clk) begin
    if (tile_push) begin
      lo_sr <= tile_row.plane_lo;
      hi_sr <= tile_row.plane_hi;
    end else if (busy_q) begin
      lo_sr <= lo_sr << 1;
      hi_sr <= hi_sr << 1;
    end
  end

  assign tile_ready = !flush && !busy_q && (fifo_count <= ready_level);
  assign write_en   = busy_q;
  assign write_data = {hi_sr[7], lo_sr[7]};

  a_push_when_ready: assert property (
    @(posedge clk) disable iff (reset)
    tile_push |-> tile_ready
  );

endmodule

// File: hw/pixel_fifo.sv
`include "ppu_consts.svh"

module pixel_fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 write_en,
  input  ppu_pkg::gb_color_t   write_data,
  input  logic                 read_en,
  output ppu_pkg::gb_color_t   read_data,
  output logic                 empty,
  output ppu_pkg::fifo_count_t count
);

  localparam int ptr_w = $clog2(`PPU_FIFO_DEPTH);
  localparam ppu_pkg::fifo_count_t depth = ppu_pkg::fifo_count_t'(`PPU_FIFO_DEPTH);

  ppu_pkg::gb_color_t   mem [`PPU_FIFO_DEPTH];
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  ppu_pkg::fifo_count_t count_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else if (flush) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (write_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (read_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({write_en, read_en})
        2'b10:   count_q <= count_q + 5'd1;
        2'b01:   count_q <= count_q - 5'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[wr_ptr] <= write_data;
    end
  end

  // Head entry is always on the output
  assign read_data = mem[rd_ptr];
  assign empty     = (count_q == '0);
  assign count     = count_q;

  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset || flush) write_en |-> count_q != depth
  );

  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset || flush) read_en |-> !empty
  );

endmodule

// File: hw/bg_palette.sv
module bg_palette (
  input  logic               clk,
  input  logic               reset,
  input  logic               palette_wr,
  input  logic [7:0]         palette_data,
  input  ppu_pkg::gb_color_t color,
  output ppu_pkg::gb_shade_t shade
);

  // Identity mapping, colour n gives shade n
  localparam logic [7:0] palette_init = 8'hE4;

  logic [7:0] palette_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      palette_q <= palette_init;
    end else if (palette_wr) begin
      palette_q <= palette_data;
    end
  end

  // Two bits per colour, colour 0 in the low bits
  assign shade = palette_q[{color, 1'b0} +: 2];

endmodule

// File: hw/framebuffer.sv
`include "ppu_consts.svh"

module framebuffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               flush,
  input  logic               dot_en,
  input  logic               fifo_empty,
  input  ppu_pkg::gb_shade_t shade,
  output logic               read_en,
  output logic               line_done,
  output logic               frame_done,
  input  ppu_pkg::fb_addr_t  rd_addr,
  output ppu_pkg::gb_shade_t rd_data
);

  localparam int num_pixels = `PPU_SCREEN_WIDTH * `PPU_SCREEN_HEIGHT;
  localparam ppu_pkg::screen_coord_t width  = ppu_pkg::screen_coord_t'(`PPU_SCREEN_WIDTH);
  localparam ppu_pkg::screen_coord_t height = ppu_pkg::screen_coord_t'(`PPU_SCREEN_HEIGHT);

  ppu_pkg::gb_shade_t     mem [num_pixels];
  ppu_pkg::screen_coord_t x_q;
  ppu_pkg::screen_coord_t y_q;
  ppu_pkg::fb_addr_t      write_addr;
  logic                   visible;
  logic                   last_x;
  logic                   last_y;

  assign write_addr = ppu_pkg::fb_addr_t'(y_q) * ppu_pkg::fb_addr_t'(`PPU_SCREEN_WIDTH)
                    + ppu_pkg::fb_addr_t'(x_q);
  assign visible    = (x_q < width) && (y_q < height);
  assign last_x     = (x_q == width - 8'd1);
  assign last_y     = (y_q == height - 8'd1);

  // Hold off while line_done is up, mode 3 ends on the next edge
  assign read_en = dot_en && !fifo_empty && visible && !line_done && !flush;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_q        <= '0;
      y_q        <= '0;
      line_done  <= 1'b0;
      frame_done <= 1'b0;
    end else if (flush) begin
      x_q        <= '0;
      y_q        <= '0;
      line_done  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      line_done  <= read_en && last_x;
      frame_done <= read_en && last_x && last_y;
      if (read_en) begin
        if (last_x) begin
          x_q <= '0;
          y_q <= last_y ? '0 : y_q + 8'd1;
        end else begin
          x_q <= x_q + 8'd1;
        end
      end
    end
  end

  // Pixel store and host read port
  always_ff @(posedge clk) begin
    if (read_en) begin
      mem[write_addr] <= shade;
    end
    rd_data <= mem[rd_addr];
  end

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    read_en |-> write_addr < ppu_pkg::fb_addr_t'(num_pixels)
  );

endmodule

// File: hw/ppu_pixel_path.sv
module ppu_pixel_path (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   lcd_enable,
  input  logic                   tile_push,
  input  ppu_pkg::tile_row_t     tile_row,
  output logic                   tile_ready,
  input  logic                   palette_wr,
  input  logic [7:0]             palette_data,
  input  ppu_pkg::fb_addr_t      rd_addr,
  output ppu_pkg::gb_shade_t     rd_data,
  output ppu_pkg::ppu_mode_t     mode,
  output ppu_pkg::screen_coord_t ly,
  output logic                   line_done,
  output logic                   frame_done
);

  logic                 flush;
  logic                 dot_en;
  logic                 fifo_write_en;
  ppu_pkg::gb_color_t   fifo_write_data;
  logic                 fifo_read_en;
  ppu_pkg::gb_color_t   fifo_head;
  logic                 fifo_empty;
  ppu_pkg::fifo_count_t fifo_count;
  ppu_pkg::gb_shade_t   pixel_shade;

  // LCD off clears every block
  assign flush = !lcd_enable;

  ppu_mode_ctrl u_mode_ctrl (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .line_done (line_done),
    .dot_en    (dot_en),
    .mode      (mode),
    .ly        (ly)
  );

  tile_row_decoder u_decoder (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .tile_push  (tile_push),
    .tile_row   (tile_row),
    .fifo_count (fifo_count),
    .tile_ready (tile_ready),
    .write_en   (fifo_write_en),
    .write_data (fifo_write_data)
  );

  pixel_fifo u_fifo (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .write_en   (fifo_write_en),
    .write_data (fifo_write_data),
    .read_en    (fifo_read_en),
    .read_data  (fifo_head),
    .empty      (fifo_empty),
    .count      (fifo_count)
  );

  bg_palette u_palette (
    .clk          (clk),
    .reset        (reset),
    .palette_wr   (palette_wr),
    .palette_data (palette_data),
    .color        (fifo_head),
    .shade        (pixel_shade)
  );

  framebuffer u_framebuffer (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .dot_en     (dot_en),
    .fifo_empty (fifo_empty),
    .shade      (pixel_shade),
    .read_en    (fifo_read_en),
    .line_done  (line_done),
    .frame_done (frame_done),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

endmodule

// File: test/ppu_pixel_path_tb.sv
`include "ppu_consts.svh"

module ppu_pixel_path_tb;

  localparam int width = `PPU_SCREEN_WIDTH;
  localparam int num_pixels = `PPU_SCREEN_WIDTH * `PPU_SCREEN_HEIGHT;
  localparam int frame_cycles = `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME;
  localparam int timeout_cycles = 4 * frame_cycles + 4 * 25000;

  logic                   clk;
  logic                   reset;
  logic                   lcd_enable;
  logic                   tile_push;
  ppu_pkg::tile_row_t     tile_row;
  logic                   tile_ready;
  logic                   palette_wr;
  logic [7:0]             palette_data;
  ppu_pkg::fb_addr_t      rd_addr;
  ppu_pkg::gb_shade_t     rd_data;
  ppu_pkg::ppu_mode_t     mode;
  ppu_pkg::screen_coord_t ly;
  logic                   line_done;
  logic                   frame_done;

  // Rows accepted since the last flush, in push order
  ppu_pkg::tile_row_t row_q[$];
  logic [7:0]         frame_pal [8];
  logic [7:0]         cur_palette;
  integer             seed = 32'hb8c3;
  int                 errors = 0;
  int                 cycle_count = 0;
  int                 frame_idx = 0;
  int                 frames_total = 0;
  int                 flush_left = 0;
  bit                 gap_mode = 0;
  bit                 sweep_busy = 0;

  // Line timing monitor state
  int                 line_cycle;
  int                 cur_ly;
  int                 done_idx;
  int                 exp_len;
  ppu_pkg::ppu_mode_t exp_mode;

  ppu_pixel_path uut (
    .clk          (clk),
    .reset        (reset),
    .lcd_enable   (lcd_enable),
    .tile_push    (tile_push),
    .tile_row     (tile_row),
    .tile_ready   (tile_ready),
    .palette_wr   (palette_wr),
    .palette_data (palette_data),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .mode         (mode),
    .ly           (ly),
    .line_done    (line_done),
    .frame_done   (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Pixel n of the stream is bit 7 - n%8 of row n/8
  function automatic ppu_pkg::gb_shade_t expected_shade(input int f, input int x, input int y);
    int                 n;
    int                 b;
    int                 ci;
    ppu_pkg::tile_row_t r;
    logic [7:0]         pal;
    n = f * num_pixels + y * width + x;
    b = 7 - (n % 8);
    r = row_q[n / 8];
    ci = {r.plane_hi[b], r.plane_lo[b]};
    pal = frame_pal[f];
    return pal[2 * ci +: 2];
  endfunction

  task automatic sweep_frame(input int f);
    int a;
    if (row_q.size() < (f + 1) * num_pixels / 8) begin
      $display("Frame %0d finished with fewer rows pushed than pixels drawn", f);
      $display("TEST FAILED");
      $fatal(1, "row queue too short");
    end
    // Read data lags the address by one cycle
    for (a = 0; a <= num_pixels; a++) begin
      @(posedge clk);
      #1;
      if (a > 0) begin
        check_value($sformatf("rd_data[%0d]", a - 1), rd_data,
                    expected_shade(f, (a - 1) % width, (a - 1) / width));
      end
      if (a < num_pixels) begin
        rd_addr = ppu_pkg::fb_addr_t'(a);
      end
    end
    sweep_busy = 0;
  endtask

  task automatic wait_frames(input int n);
    while (frames_total < n) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_sweep_done();
    while (sweep_busy) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Simulation ran for %0d cycles without finishing", cycle_count);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  // Feeder, also owns lcd_enable so flush and pushes never race
  initial begin
    @(negedge reset);
    forever begin
      @(posedge clk);
      #1;
      tile_push = 1'b0;
      if (flush_left > 0) begin
        lcd_enable = 1'b0;
        flush_left--;
        row_q.delete();
        frame_idx = 0;
      end else if (!lcd_enable) begin
        lcd_enable = 1'b1;
      end else if (tile_ready) begin
        if (!gap_mode || ($random(seed) & 3) == 0) begin
          tile_row = ppu_pkg::tile_row_t'($random(seed));
          row_q.push_back(tile_row);
          tile_push = 1'b1;
        end
      end
    end
  end

  // Mode and line timing per cycle
  always @(negedge clk) begin
    if (reset || !lcd_enable) begin
      line_cycle = 0;
      cur_ly = 0;
      done_idx = -1;
    end else begin
      if (ly != cur_ly) begin
        exp_len = (done_idx + 1 > `PPU_DOTS_PER_LINE) ? done_idx + 1 : `PPU_DOTS_PER_LINE;
        check_value("line length", line_cycle, exp_len);
        check_value("ly", ly, (cur_ly + 1) % `PPU_LINES_PER_FRAME);
        cur_ly = ly;
        line_cycle = 0;
        done_idx = -1;
      end
      if (cur_ly >= `PPU_SCREEN_HEIGHT) begin
        exp_mode = ppu_pkg::mode_vblank;
      end else if (line_cycle < `PPU_OAM_SCAN_DOTS) begin
        exp_mode = ppu_pkg::mode_oam_scan;
      end else if (done_idx < 0) begin
        exp_mode = ppu_pkg::mode_draw;
      end else begin
        exp_mode = ppu_pkg::mode_hblank;
      end
      check_value("mode", mode, exp_mode);
      if (exp_mode != ppu_pkg::mode_draw) begin
        check_value("line_done", line_done, 1'b0);
      end
      check_value("frame_done", frame_done,
                  line_done && (cur_ly == `PPU_SCREEN_HEIGHT - 1));
      if (line_done) begin
        done_idx = line_cycle;
      end
      line_cycle++;
    end
  end

  // Readback after every finished frame
  initial begin : readback
    int f;
    forever begin
      @(negedge clk);
      if (!reset && frame_done) begin
        frame_pal[frame_idx] = cur_palette;
        f = frame_idx;
        frame_idx++;
        sweep_busy = 1;
        frames_total++;
        sweep_frame(f);
      end
    end
  end

  initial begin
    reset = 1'b1;
    lcd_enable = 1'b1;
    tile_push = 1'b0;
    tile_row = '0;
    palette_wr = 1'b0;
    palette_data = 8'h00;
    rd_addr = '0;
    cur_palette = 8'hE4;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    check_value("mode", mode, ppu_pkg::mode_oam_scan);
    check_value("ly", ly, 0);
    check_value("line_done", line_done, 1'b0);
    check_value("frame_done", frame_done, 1'b0);
    check_value("tile_ready", tile_ready, 1'b1);

    // First frame, then invert the palette in vblank
    wait_frames(1);
    while (mode != ppu_pkg::mode_vblank) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    palette_wr = 1'b1;
    palette_data = 8'h1B;
    cur_palette = 8'h1B;
    @(posedge clk);
    #1 palette_wr = 1'b0;

    // Third frame drawn with a starved FIFO
    wait_frames(2);
    gap_mode = 1;
    wait_frames(3);
    gap_mode = 0;
    wait_sweep_done();

    // LCD off partway through a frame
    while (ly != 8'd80) begin
      @(negedge clk);
    end
    flush_left = 4;
    @(negedge clk);
    while (!lcd_enable) begin
      @(negedge clk);
    end
    check_value("mode", mode, ppu_pkg::mode_oam_scan);
    check_value("ly", ly, 0);
    check_value("line_done", line_done, 1'b0);

    wait_frames(4);
    wait_sweep_done();
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+hw
hw/ppu_pkg.sv
hw/ppu_mode_ctrl.sv
hw/tile_row_decoder.sv
hw/pixel_fifo.sv
hw/bg_palette.sv
hw/framebuffer.sv
hw/ppu_pixel_path.sv
test/ppu_pixel_path_tb.sv

// File: Bender.yml
package:
  name: ppu_pixel_path

export_include_dirs:
  - hw

sources:
  - files:
      - hw/ppu_pkg.sv
      - hw/ppu_mode_ctrl.sv
      - hw/tile_row_decoder.sv
      - hw/pixel_fifo.sv
      - hw/bg_palette.sv
      - hw/framebuffer.sv
      - hw/ppu_pixel_path.sv
  - target: test
    files:
      - test/ppu_pixel_path_tb.sv
